// File: hdl/fifo_settings.svh
`ifndef FIFO_SETTINGS_SVH
`define FIFO_SETTINGS_SVH

// ----------------------------------------------------------
// FIFO build settings
// ----------------------------------------------------------

// Width of one data word in bits
`define FIFO_DATA_WID 16

// Number of words held in the storage array
`define FIFO_DEPTH 32

// Read mode
//   1: first-word-fall-through, head word shown on rd_data
//   0: standard read, data returned with rd_ack one cycle later
`define FIFO_FWFT 1

`endif

// File: hdl/fifo_pkg.sv
`default_nettype none

`include "fifo_settings.svh"

package fifo_pkg;

    // Derived widths
    localparam int ADDR_WID = $clog2(`FIFO_DEPTH);
    // FWFT needs room for the output register on top of storage
    localparam int CNT_WID  = (`FIFO_FWFT != 0) ? $clog2(`FIFO_DEPTH + 1 + 1)
                                                : $clog2(`FIFO_DEPTH + 1);

    // One payload word
    typedef logic [`FIFO_DATA_WID-1:0] data_t;

    // Storage address
    typedef logic [ADDR_WID-1:0] addr_t;

    // Occupancy count
    typedef logic [CNT_WID-1:0] count_t;

    // Read-side controller states
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_HOLD
    } rd_state_t;

endpackage : fifo_pkg

`default_nettype wire

// File: hdl/fifo_ptr_ctr.sv
`default_nettype none

`include "fifo_settings.svh"

module fifo_ptr_ctr (
    input  logic             clk,
    input  logic             arst_n,

    // Requests
    input  logic             wr,
    input  logic             mem_rd,

    // Storage control
    output logic             mem_we,
    output fifo_pkg::addr_t  wr_addr,
    output fifo_pkg::addr_t  rd_addr,

    // Status
    output fifo_pkg::count_t wr_count,
    output logic             full,
    output logic             mem_empty,
    output logic             oflow,
    output logic             uflow_mem
);

    import fifo_pkg::*;

    // ----------------------------------------------------------
    // Signals
    // ----------------------------------------------------------
    addr_t  wr_ptr;
    addr_t  rd_ptr;
    count_t occ;
    logic   mem_re;

    // Blocked requests are dropped here
    assign mem_we = wr && !full;
    assign mem_re = mem_rd && !mem_empty;

    // ----------------------------------------------------------
    // Pointers
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
        end else if (mem_we) begin
            if (wr_ptr == addr_t'(`FIFO_DEPTH - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + addr_t'(1);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
        end else if (mem_re) begin
            if (rd_ptr == addr_t'(`FIFO_DEPTH - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + addr_t'(1);
            end
        end
    end

    assign wr_addr = wr_ptr;
    assign rd_addr = rd_ptr;

    // ----------------------------------------------------------
    // Occupancy
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            occ <= '0;
        end else begin
            case ({mem_we, mem_re})
                2'b10:   occ <= occ + count_t'(1);
                2'b01:   occ <= occ - count_t'(1);
                default: occ <= occ;
            endcase
        end
    end

    assign wr_count  = occ;
    assign full      = (occ == count_t'(`FIFO_DEPTH));
    assign mem_empty = (occ == '0);

    // Error pulses, one cycle after the offending edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            oflow     <= 1'b0;
            uflow_mem <= 1'b0;
        end else begin
            oflow     <= wr && full;
            uflow_mem <= mem_rd && mem_empty;
        end
    end

    // ----------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------
    // Pointers coincide exactly when storage is empty or full
    a_ptr_match: assert property (
        @(posedge clk) disable iff (!arst_n)
        (wr_ptr == rd_ptr) == (mem_empty || full)
    );

    a_occ_in_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        occ <= count_t'(`FIFO_DEPTH)
    );

endmodule : fifo_ptr_ctr

`default_nettype wire

// File: hdl/fifo_mem.sv
`default_nettype none

`include "fifo_settings.svh"

module fifo_mem (
    input  logic            clk,

    // Write port
    input  logic            mem_we,
    input  fifo_pkg::addr_t wr_addr,
    input  fifo_pkg::data_t wr_data,

    // Read port, data valid the cycle after rd_en
    input  logic            rd_en,
    input  fifo_pkg::addr_t rd_addr,
    output fifo_pkg::data_t mem_rdata
);

    import fifo_pkg::*;

    // ----------------------------------------------------------
    // Storage array
    // ----------------------------------------------------------
    data_t mem [0:`FIFO_DEPTH-1];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read port, maps onto block RAM output register
    always_ff @(posedge clk) begin
        if (rd_en) begin
            mem_rdata <= mem[rd_addr];
        end
    end

endmodule : fifo_mem

`default_nettype wire

// File: hdl/fifo_rd_fsm.sv
`default_nettype none

`include "fifo_settings.svh"

module fifo_rd_fsm (
    input  logic             clk,
    input  logic             arst_n,

    // Reader side
    input  logic             rd,

    // From storage
    input  logic             mem_empty,
    input  fifo_pkg::data_t  mem_rdata,

    // Fetch request to pointer logic and storage
    output logic             mem_rd,

    // Reader outputs
    output fifo_pkg::data_t  rd_data,
    output logic             rd_ack,
    output logic             empty,
    output fifo_pkg::count_t rd_count,
    output logic             uflow,

    // Storage occupancy
    input  fifo_pkg::count_t wr_count
);

    import fifo_pkg::*;

    // ----------------------------------------------------------
    // Signals
    // ----------------------------------------------------------
    rd_state_t state;
    rd_state_t state_nxt;
    logic      load;
    logic      out_occ;
    data_t     out_q;

    // ----------------------------------------------------------
    // Next state and fetch decode
    // ----------------------------------------------------------
    always_comb begin
        state_nxt = state;
        mem_rd    = 1'b0;
        load      = 1'b0;
        if (`FIFO_FWFT != 0) begin
            case (state)
                RD_IDLE: begin
                    if (!mem_empty) begin
                        mem_rd    = 1'b1;
                        state_nxt = RD_FETCH;
                    end
                end
                // Storage data arrives this cycle
                RD_FETCH: begin
                    load      = 1'b1;
                    state_nxt = RD_HOLD;
                end
                RD_HOLD: begin
                    if (rd) begin
                        // Refill in the same cycle as the pop
                        if (!mem_empty) begin
                            mem_rd    = 1'b1;
                            state_nxt = RD_FETCH;
                        end else begin
                            state_nxt = RD_IDLE;
                        end
                    end
                end
                default: state_nxt = RD_IDLE;
            endcase
        end else begin
            // Standard read: one fetch per accepted rd
            mem_rd    = rd && !mem_empty;
            state_nxt = mem_rd ? RD_FETCH : RD_IDLE;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= RD_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ----------------------------------------------------------
    // Output register
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (load) begin
            out_q <= mem_rdata;
        end
    end

    assign rd_data = (`FIFO_FWFT != 0) ? out_q : mem_rdata;
    assign empty   = (`FIFO_FWFT != 0) ? (state != RD_HOLD) : mem_empty;
    assign rd_ack  = (`FIFO_FWFT != 0) ? (rd && !empty) : (state == RD_FETCH);

    // Word in flight or held counts as readable
    assign out_occ  = (`FIFO_FWFT != 0) && (state != RD_IDLE);
    assign rd_count = wr_count + count_t'(out_occ);

    // Read while empty
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            uflow <= 1'b0;
        end else begin
            uflow <= rd && empty;
        end
    end

    // ----------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------
    // Readable words never exceed storage plus the output register
    a_rd_count_max: assert property (
        @(posedge clk) disable iff (!arst_n)
        rd_count <= count_t'(`FIFO_DEPTH + 1)
    );

    // A fetch always has a stored word behind it
    a_fetch_has_word: assert property (
        @(posedge clk) disable iff (!arst_n)
        mem_rd |-> (wr_count != '0)
    );

endmodule : fifo_rd_fsm

`default_nettype wire

// File: hdl/fifo_sync.sv
`default_nettype none

module fifo_sync (
    input  logic             clk,
    input  logic             arst_n,

    // Write interface
    input  logic             wr,
    input  fifo_pkg::data_t  wr_data,
    output fifo_pkg::count_t wr_count,
    output logic             full,
    output logic             oflow,

    // Read interface
    input  logic             rd,
    output logic             rd_ack,
    output fifo_pkg::data_t  rd_data,
    output fifo_pkg::count_t rd_count,
    output logic             empty,
    output logic             uflow
);

    import fifo_pkg::*;

    // ----------------------------------------------------------
    // Internal wiring
    // ----------------------------------------------------------
    logic   mem_we;
    addr_t  wr_addr;
    addr_t  rd_addr;
    logic   mem_rd;
    logic   mem_empty;
    data_t  mem_rdata;
    logic   uflow_mem;
    logic   uflow_rd;

    // ----------------------------------------------------------
    // Pointer and occupancy counter
    // ----------------------------------------------------------
    fifo_ptr_ctr fifo_ptr_ctr_i (
        .clk       ( clk ),
        .arst_n    ( arst_n ),
        .wr        ( wr ),
        .mem_rd    ( mem_rd ),
        .mem_we    ( mem_we ),
        .wr_addr   ( wr_addr ),
        .rd_addr   ( rd_addr ),
        .wr_count  ( wr_count ),
        .full      ( full ),
        .mem_empty ( mem_empty ),
        .oflow     ( oflow ),
        .uflow_mem ( uflow_mem )
    );

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------
    fifo_mem fifo_mem_i (
        .clk       ( clk ),
        .mem_we    ( mem_we ),
        .wr_addr   ( wr_addr ),
        .wr_data   ( wr_data ),
        .rd_en     ( mem_rd ),
        .rd_addr   ( rd_addr ),
        .mem_rdata ( mem_rdata )
    );

    // ----------------------------------------------------------
    // Read-side controller
    // ----------------------------------------------------------
    fifo_rd_fsm fifo_rd_fsm_i (
        .clk       ( clk ),
        .arst_n    ( arst_n ),
        .rd        ( rd ),
        .mem_empty ( mem_empty ),
        .mem_rdata ( mem_rdata ),
        .mem_rd    ( mem_rd ),
        .rd_data   ( rd_data ),
        .rd_ack    ( rd_ack ),
        .empty     ( empty ),
        .rd_count  ( rd_count ),
        .uflow     ( uflow_rd ),
        .wr_count  ( wr_count )
    );

    // Reader-side and storage-side underflow share one flag
    assign uflow = uflow_rd || uflow_mem;

endmodule : fifo_sync

`default_nettype wire

// File: tests/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
    output logic clk
);

    // Free-running clock, period 4
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

endmodule : tb_clk_gen

`default_nettype wire

// File: tests/fifo_sync_tb.sv
`default_nettype none

`include "fifo_settings.svh"

module fifo_sync_tb;

    // ----------------------------------------------------------
    // Constants and table storage
    // ----------------------------------------------------------
    localparam int NUM_ROWS      = 7;
    localparam int SETTLE_CYCLES = 4;
    localparam int RESET_CYCLES  = 3;
    // Storage words plus the output register
    localparam int CAPACITY      = `FIFO_DEPTH + 1;

    localparam int OP_IDLE     = 0;
    localparam int OP_WRITE    = 1;
    localparam int OP_READ     = 2;
    localparam int OP_RD_EMPTY = 3;
    localparam int OP_MIXED    = 4;

    int row_op       [NUM_ROWS];
    int row_cycles   [NUM_ROWS];
    int row_full     [NUM_ROWS];
    int row_empty    [NUM_ROWS];
    int row_oflow    [NUM_ROWS];
    int row_uflow    [NUM_ROWS];
    // -1 takes the reference queue length
    int row_rd_count [NUM_ROWS];
    int rows_loaded;
    bit table_loaded;

    // ----------------------------------------------------------
    // DUT signals
    // ----------------------------------------------------------
    logic              clk;
    logic              arst_n;
    logic              wr;
    fifo_pkg::data_t   wr_data;
    fifo_pkg::count_t  wr_count;
    logic              full;
    logic              oflow;
    logic              rd;
    logic              rd_ack;
    fifo_pkg::data_t   rd_data;
    fifo_pkg::count_t  rd_count;
    logic              empty;
    logic              uflow;

    fifo_pkg::data_t   model_q [$];
    logic [31:0]       lfsr_state;
    int                error_count;
    int                rows_passed;
    int                rows_failed;
    bit                oflow_seen;
    bit                uflow_seen;

    tb_clk_gen clk_gen_i (
        .clk ( clk )
    );

    fifo_sync fifo_sync_i (
        .clk      ( clk ),
        .arst_n   ( arst_n ),
        .wr       ( wr ),
        .wr_data  ( wr_data ),
        .wr_count ( wr_count ),
        .full     ( full ),
        .oflow    ( oflow ),
        .rd       ( rd ),
        .rd_ack   ( rd_ack ),
        .rd_data  ( rd_data ),
        .rd_count ( rd_count ),
        .empty    ( empty ),
        .uflow    ( uflow )
    );

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic fb;
        // Taps 32, 22, 2, 1
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    // One LFSR step per data bit
    function automatic fifo_pkg::data_t next_word();
        fifo_pkg::data_t word;
        int              i;
        for (i = 0; i < `FIFO_DATA_WID; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            word[i]    = lfsr_state[0];
        end
        return word;
    endfunction

    function automatic string op_name(input int op);
        case (op)
            OP_IDLE:     return "idle";
            OP_WRITE:    return "write burst";
            OP_READ:     return "read burst";
            OP_RD_EMPTY: return "read while empty";
            OP_MIXED:    return "write and read";
            default:     return "unknown";
        endcase
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t: %s mismatch, got 0x%0h expected 0x%0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic add_row(input int op, input int cycles, input int exp_full,
                           input int exp_empty, input int exp_oflow, input int exp_uflow,
                           input int exp_rd_count);
        row_op[rows_loaded]       = op;
        row_cycles[rows_loaded]   = cycles;
        row_full[rows_loaded]     = exp_full;
        row_empty[rows_loaded]    = exp_empty;
        row_oflow[rows_loaded]    = exp_oflow;
        row_uflow[rows_loaded]    = exp_uflow;
        row_rd_count[rows_loaded] = exp_rd_count;
        rows_loaded++;
    endtask

    // Drive one cycle on the falling edge and update the reference queue
    task automatic run_cycle(input bit do_wr, input bit do_rd, input bit force_rd);
        int              level;
        bit              pop;
        bit              exp_ack;
        fifo_pkg::data_t word;
        fifo_pkg::data_t head;
        @(negedge clk);
        level   = model_q.size();
        // The reader strobes once a word is shown, unless forced
        pop     = force_rd || (do_rd && !empty);
        exp_ack = pop && (level != 0);
        rd      = pop;
        if (level == 0) begin
            check_value(empty, 1'b1, "empty with nothing written");
        end
        if (exp_ack) begin
            head = model_q.pop_front();
            check_value(rd_data, head, "rd_data");
        end
        wr = do_wr;
        if (do_wr) begin
            word    = next_word();
            wr_data = word;
            // Dropped when storage and output register are both occupied
            if (level < CAPACITY) begin
                model_q.push_back(word);
            end
        end
        #1;
        check_value(rd_ack, exp_ack, "rd_ack");
    endtask

    task automatic load_table();
        //      op           cycles           full empty oflow uflow rd_count
        add_row(OP_IDLE,     0,               0,   1,    0,    0,    0);
        add_row(OP_WRITE,    `FIFO_DEPTH + 1, 1,   0,    0,    0,    CAPACITY);
        add_row(OP_WRITE,    1,               1,   0,    1,    0,    CAPACITY);
        add_row(OP_READ,     80,              0,   1,    0,    0,    0);
        add_row(OP_RD_EMPTY, 1,               0,   1,    0,    1,    0);
        add_row(OP_MIXED,    40,              0,   0,    0,    0,    -1);
        add_row(OP_READ,     80,              0,   1,    0,    0,    0);
        table_loaded = 1'b1;
    endtask

    // ----------------------------------------------------------
    // Flag monitor, pulses sampled where stable
    // ----------------------------------------------------------
    always @(negedge clk) begin
        if (oflow) begin
            oflow_seen = 1'b1;
        end
        if (uflow) begin
            uflow_seen = 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Watchdog
    // ----------------------------------------------------------
    initial begin : watchdog
        int longest;
        int limit;
        int r;
        longest = 0;
        wait (table_loaded);
        for (r = 0; r < NUM_ROWS; r++) begin
            if (row_cycles[r] + SETTLE_CYCLES > longest) begin
                longest = row_cycles[r] + SETTLE_CYCLES;
            end
        end
        // Double the nominal length for margin
        limit = 2 * (NUM_ROWS * longest + RESET_CYCLES + 2) * 4;
        #(limit);
        $display("Simulation timed out at %0t before all rows finished", $time);
        $display("Test failed");
        $finish;
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin : main
        int r;
        int c;
        int errors_before;
        int exp_rd;
        int exp_wr;
        arst_n       = 1'b0;
        wr           = 1'b0;
        wr_data      = '0;
        rd           = 1'b0;
        lfsr_state   = 32'hd36c;
        error_count  = 0;
        rows_passed  = 0;
        rows_failed  = 0;
        rows_loaded  = 0;
        table_loaded = 1'b0;
        oflow_seen   = 1'b0;
        uflow_seen   = 1'b0;

        load_table();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (r = 0; r < NUM_ROWS; r++) begin
            errors_before = error_count;
            oflow_seen    = 1'b0;
            uflow_seen    = 1'b0;
            for (c = 0; c < row_cycles[r]; c++) begin
                case (row_op[r])
                    OP_WRITE:    run_cycle(1'b1, 1'b0, 1'b0);
                    OP_READ:     run_cycle(1'b0, 1'b1, 1'b0);
                    OP_RD_EMPTY: run_cycle(1'b0, 1'b0, 1'b1);
                    OP_MIXED:    run_cycle(1'b1, 1'b1, 1'b0);
                    default:     run_cycle(1'b0, 1'b0, 1'b0);
                endcase
            end
            repeat (SETTLE_CYCLES) run_cycle(1'b0, 1'b0, 1'b0);

            // Status after the idle gap
            exp_rd = (row_rd_count[r] < 0) ? model_q.size() : row_rd_count[r];
            exp_wr = (model_q.size() > 0) ? model_q.size() - 1 : 0;
            check_value(full, row_full[r], "full");
            check_value(empty, row_empty[r], "empty");
            check_value(oflow_seen, row_oflow[r], "oflow seen");
            check_value(uflow_seen, row_uflow[r], "uflow seen");
            check_value(rd_count, exp_rd, "rd_count");
            check_value(wr_count, exp_wr, "wr_count");

            if (error_count == errors_before) begin
                rows_passed++;
                $display("row %0d %s: PASS", r, op_name(row_op[r]));
            end else begin
                rows_failed++;
                $display("row %0d %s: FAIL with %0d errors", r, op_name(row_op[r]),
                         error_count - errors_before);
            end
        end

        $display("rows passed %0d, rows failed %0d, errors %0d",
                 rows_passed, rows_failed, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : fifo_sync_tb

`default_nettype wire

// File: sim.f
+incdir+hdl
hdl/fifo_pkg.sv
hdl/fifo_ptr_ctr.sv
hdl/fifo_mem.sv
hdl/fifo_rd_fsm.sv
hdl/fifo_sync.sv
tests/tb_clk_gen.sv
tests/fifo_sync_tb.sv
